// File: sim.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/pipeControl.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/mipsCore.sv
verif/coreTb.sv

// File: verif/programInput.txt
// Hex words: program length, program from 3000, end address,
// write count then (pc reg value) lines, store count then (addr data) lines
20
3C011234 34215678 34020010 00221821
00612023 00822821 ACA30000 ACA50004
8CA60000 00C23821 10820003 34080001
340900FF 340900EE 10220005 340A0002
340B0003 0C000C15 340C0004 340D0BAD
340D0BAD 03E07021 8C0F0024 AC0F0028
8C100028 120F0003 020E8821 3412DEAD
3412DEAD 08000C20 02309823 34140BAD
00003080
12
00003000 01 12340000
00003004 01 12345678
00003008 02 00000010
0000300C 03 12345688
00003010 04 00000010
00003014 05 00000020
00003020 06 12345688
00003024 07 12345698
0000302C 08 00000001
0000303C 0A 00000002
00003040 0B 00000003
00003044 1F 0000304C
00003048 0C 00000004
00003054 0E 0000304C
00003058 0F 00000020
00003060 10 00000020
00003068 11 0000306C
00003078 13 0000304C
3
00000020 12345688
00000024 00000020
00000028 00000020

// File: verif/coreTb.sv
module coreTb
    import isaPkg::*;
    import pipePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxCycles = 2000;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] dataRead;
    logic [31:0] instrAddr;
    memReqT      dataReq;
    logic        wbValid;
    wbT          wbInfo;

    logic [31:0] fileWords [0:255];
    logic [31:0] progMem [0:63];
    logic [31:0] dataMem [0:1023];
    logic [31:0] fetchOffset;
    logic [31:0] endAddr;
    int          progLen;
    int          sinceReset;
    int          writesSeen;
    int          storesSeen;
    wbT          expWrites [$];
    memReqT      expStores [$];

    mipsCore dut0 (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .dataReq(dataReq), .dataRead(dataRead), .wbValid(wbValid), .wbInfo(wbInfo)
    );

    always #5 clk = ~clk;

    // Instruction memory, nop past the end of the program
    assign fetchOffset = instrAddr - resetPc;
    assign instr = (instrAddr >= resetPc && fetchOffset[31:2] < progLen) ?
                   progMem[fetchOffset[31:2]] : 32'h0000_0000;

    // Data memory, 4 KB of words
    assign dataRead = dataMem[dataReq.addr[11:2]];

    always @(posedge clk) begin
        if (dataReq.we === 1'b1) begin
            dataMem[dataReq.addr[11:2]] <= dataReq.wdata;
        end
    end

    // Rising edges since reset went low
    always @(posedge clk) begin
        if (reset) begin
            sinceReset <= 0;
        end else begin
            sinceReset <= sinceReset + 1;
        end
    end

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWrite(input wbT got);
        wbT exp;
        if (expWrites.size() == 0) begin
            $display("unexpected register write to r%0d from pc %h after all expected writes",
                     got.dest, got.pc);
            abortRun();
        end else begin
            exp = expWrites.pop_front();
            if (got != exp) begin
                $display("mismatch at %0t: write %0d expected pc=%h r%0d=%h, got pc=%h r%0d=%h",
                         $time, writesSeen, exp.pc, exp.dest, exp.value,
                         got.pc, got.dest, got.value);
                abortRun();
            end
            writesSeen++;
        end
    endtask

    task automatic checkStore(input memReqT got);
        memReqT exp;
        if (expStores.size() == 0) begin
            $display("unexpected store to address %h after all expected stores", got.addr);
            abortRun();
        end else begin
            exp = expStores.pop_front();
            if (got != exp) begin
                $display("mismatch at %0t: store %0d expected [%h]=%h, got [%h]=%h",
                         $time, storesSeen, exp.addr, exp.wdata, got.addr, got.wdata);
                abortRun();
            end
            storesSeen++;
        end
    endtask

    // Outputs are sampled away from the rising edge
    always @(negedge clk) begin
        if (wbValid === 1'b1) begin
            if (writesSeen == 0 && sinceReset != 4) begin
                $display("mismatch at %0t: first write-back %0d cycles after reset, expected 4",
                         $time, sinceReset);
                abortRun();
            end
            checkWrite(wbInfo);
        end
        if (dataReq.we === 1'b1) begin
            checkStore(dataReq);
        end
    end

    initial begin
        int     idx;
        int     count;
        int     waited;
        wbT     w;
        memReqT s;

        clk        = 1'b0;
        reset      = 1'b1;
        progLen    = 0;
        writesSeen = 0;
        storesSeen = 0;
        for (int a = 0; a < 1024; a++) begin
            dataMem[a] = '0;
        end

        $readmemh("verif/programInput.txt", fileWords);
        if ($isunknown(fileWords[0])) begin
            $display("could not read verif/programInput.txt");
            abortRun();
        end

        // Program, end address, then the write and store lists
        idx   = 0;
        count = fileWords[idx];
        idx++;
        for (int k = 0; k < count; k++) begin
            progMem[k] = fileWords[idx];
            idx++;
        end
        progLen = count;
        endAddr = fileWords[idx];
        idx++;
        count = fileWords[idx];
        idx++;
        for (int k = 0; k < count; k++) begin
            w.pc    = fileWords[idx];
            w.dest  = fileWords[idx + 1][4:0];
            w.value = fileWords[idx + 2];
            expWrites.push_back(w);
            idx += 3;
        end
        count = fileWords[idx];
        idx++;
        for (int k = 0; k < count; k++) begin
            s.addr  = fileWords[idx];
            s.wdata = fileWords[idx + 1];
            s.we    = 1'b1;
            expStores.push_back(s);
            idx += 2;
        end

        repeat (10) @(negedge clk);
        if (instrAddr !== resetPc || wbValid !== 1'b0 || dataReq.we !== 1'b0) begin
            $display("mismatch at %0t: after reset instrAddr=%h wbValid=%b we=%b",
                     $time, instrAddr, wbValid, dataReq.we);
            abortRun();
        end
        reset = 1'b0;

        waited = 0;
        while (instrAddr !== endAddr && waited < maxCycles) begin
            @(negedge clk);
            waited++;
        end
        if (instrAddr !== endAddr) begin
            $display("timeout while waiting for fetch to reach address %h", endAddr);
            abortRun();
        end

        // Instructions still in the pipe retire after the last fetch
        waited = 0;
        while (expWrites.size() != 0 && waited < maxCycles) begin
            @(negedge clk);
            waited++;
        end
        if (expWrites.size() != 0) begin
            $display("timeout while waiting for %0d remaining register writes",
                     expWrites.size());
            abortRun();
        end

        if (expStores.size() != 0) begin
            $display("program finished with %0d expected stores never seen", expStores.size());
            abortRun();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: logic/mipsCore.sv
module mipsCore
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output memReqT      dataReq,
    input  logic [31:0] dataRead,
    output logic        wbValid,
    output wbT          wbInfo
);

    logic        stall;
    logic        flush;
    logic        branchTaken;
    logic        jump;
    logic [31:0] pcD;
    instrU       instrD;
    ctrlT        ctrlD;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] fwdRs;
    logic [31:0] fwdRt;
    fwdSelT      exFwdRs;
    fwdSelT      exFwdRt;
    stageT       exStage;
    stageT       memStage;
    logic [31:0] memResult;
    logic [31:0] wbResult;

    fetchUnit fetch0 (
        .clk(clk), .reset(reset), .stall(stall), .branchTaken(branchTaken),
        .jump(jump), .fwdRs(fwdRs), .pcD(pcD), .instrD(instrD),
        .instrAddr(instrAddr), .instr(instr)
    );

    regFile regs0 (
        .clk(clk), .reset(reset), .rsIdx(instrD.r.rs), .rtIdx(instrD.r.rt),
        .wb(wbInfo), .wbEn(wbValid), .rsVal(rsVal), .rtVal(rtVal)
    );

    pipeControl control0 (
        .instrD(instrD), .rsVal(rsVal), .rtVal(rtVal), .memResult(memResult),
        .exStage(exStage), .memStage(memStage), .ctrlD(ctrlD), .stall(stall),
        .flush(flush), .branchTaken(branchTaken), .jump(jump), .fwdRs(fwdRs),
        .fwdRt(fwdRt), .exFwdRs(exFwdRs), .exFwdRt(exFwdRt)
    );

    executeStage execute0 (
        .clk(clk), .reset(reset), .flush(flush), .pcD(pcD), .instrD(instrD),
        .ctrlD(ctrlD), .fwdRs(fwdRs), .fwdRt(fwdRt), .exFwdRs(exFwdRs),
        .exFwdRt(exFwdRt), .memResult(memResult), .wbResult(wbResult),
        .exStage(exStage)
    );

    memWriteback memWb0 (
        .clk(clk), .reset(reset), .exStage(exStage), .dataReq(dataReq),
        .dataRead(dataRead), .memStage(memStage), .memResult(memResult),
        .wbResult(wbResult), .wbValid(wbValid), .wbInfo(wbInfo)
    );

endmodule

// File: logic/memWriteback.sv
module memWriteback
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  stageT       exStage,
    output memReqT      dataReq,
    input  logic [31:0] dataRead,
    output stageT       memStage,
    output logic [31:0] memResult,
    output logic [31:0] wbResult,
    output logic        wbValid,
    output wbT          wbInfo
);

    stageT memReg;
    stageT wbReg;
    stageT memNext;
    stageT wbNext;

    // Tnew counts down as the instruction leaves execute
    always_comb begin
        memNext = exStage;
        if (exStage.ctrl.tNew != '0) begin
            memNext.ctrl.tNew = exStage.ctrl.tNew - 2'd1;
        end
    end

    assign memResult = memReg.ctrl.memRead ? dataRead : memReg.result;

    always_comb begin
        wbNext        = memReg;
        wbNext.result = memResult;
    end

    always_ff @(posedge clk) begin
        memReg <= memNext;
        wbReg  <= wbNext;
        if (reset) begin
            memReg.ctrl <= bubbleCtrl;
            wbReg.ctrl  <= bubbleCtrl;
        end
    end

    // Word address from the ALU, store data from rt
    assign dataReq = '{addr: memReg.result, wdata: memReg.rtVal, we: memReg.ctrl.memWrite};

    assign memStage = memReg;
    assign wbResult = wbReg.result;

    // Writes to register 0 are dropped here
    assign wbValid = wbReg.ctrl.regWrite && wbReg.ctrl.dest != '0;
    assign wbInfo  = '{pc: wbReg.pc, dest: wbReg.ctrl.dest, value: wbReg.result};

endmodule

// File: logic/executeStage.sv
module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic [31:0] pcD,
    input  instrU       instrD,
    input  ctrlT        ctrlD,
    input  logic [31:0] fwdRs,
    input  logic [31:0] fwdRt,
    input  fwdSelT      exFwdRs,
    input  fwdSelT      exFwdRt,
    input  logic [31:0] memResult,
    input  logic [31:0] wbResult,
    output stageT       exStage
);

    stageT       dxReg;
    fwdSelT      rsSel;
    fwdSelT      rtSel;
    logic [31:0] opA;
    logic [31:0] opRt;
    logic [31:0] opB;
    logic [31:0] immExt;
    logic [31:0] aluOut;
    logic        isJal;

    function automatic logic [31:0] pickOperand(fwdSelT sel, logic [31:0] captured);
        case (sel)
            fwdMem:  return memResult;
            fwdWb:   return wbResult;
            default: return captured;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        dxReg.pc     <= pcD;
        dxReg.instr  <= instrD;
        dxReg.rsVal  <= fwdRs;
        dxReg.rtVal  <= fwdRt;
        // Link address, kept only by jal
        dxReg.result <= pcD + 32'd8;
        if (reset || flush) begin
            dxReg.ctrl <= bubbleCtrl;
            rsSel      <= fwdReg;
            rtSel      <= fwdReg;
        end else begin
            dxReg.ctrl <= ctrlD;
            rsSel      <= exFwdRs;
            rtSel      <= exFwdRt;
        end
    end

    always_comb begin
        opA  = pickOperand(rsSel, dxReg.rsVal);
        opRt = pickOperand(rtSel, dxReg.rtVal);
    end

    assign immExt = dxReg.ctrl.zeroExt ? {16'h0000, dxReg.instr.i.imm} :
                                         {{16{dxReg.instr.i.imm[15]}}, dxReg.instr.i.imm};
    assign opB    = dxReg.ctrl.immB ? immExt : opRt;

    always_comb begin
        case (dxReg.ctrl.aluOp)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluOr:   aluOut = opA | opB;
            aluLui:  aluOut = {opB[15:0], 16'h0000};
            default: aluOut = opA + opB;
        endcase
    end

    assign isJal = (dxReg.instr.j.opcode == opJal);

    always_comb begin
        exStage       = dxReg;
        exStage.rsVal = opA;
        exStage.rtVal = opRt;
        if (!isJal) begin
            exStage.result = aluOut;
        end
    end

    // A bubble only goes in behind a writer in execute or a load now in memory
    bubbleBehindProducer: assert property (@(posedge clk) disable iff (reset)
        flush |-> exStage.ctrl.regWrite || $past(exStage.ctrl.memRead));

endmodule

// File: logic/pipeControl.sv
module pipeControl
    import isaPkg::*;
    import pipePkg::*;
(
    input  instrU       instrD,
    input  logic [31:0] rsVal,
    input  logic [31:0] rtVal,
    input  logic [31:0] memResult,
    input  stageT       exStage,
    input  stageT       memStage,
    output ctrlT        ctrlD,
    output logic        stall,
    output logic        flush,
    output logic        branchTaken,
    output logic        jump,
    output logic [31:0] fwdRs,
    output logic [31:0] fwdRt,
    output fwdSelT      exFwdRs,
    output fwdSelT      exFwdRt
);

    tickT tUseRs;
    tickT tUseRt;
    logic isBeq;
    logic rsHitEx;
    logic rsHitMem;
    logic rtHitEx;
    logic rtHitMem;

    function automatic logic hits(ctrlT producer, regIdxT idx);
        return producer.regWrite && producer.dest != '0 && producer.dest == idx;
    endfunction

    // Single decode, the control word then travels with the instruction
    always_comb begin
        ctrlD  = bubbleCtrl;
        tUseRs = tUseNone;
        tUseRt = tUseNone;
        isBeq  = 1'b0;
        jump   = 1'b0;
        case (instrD.r.opcode)
            opSpecial: begin
                if (instrD.r.funct == fnAddu || instrD.r.funct == fnSubu) begin
                    ctrlD.aluOp    = (instrD.r.funct == fnSubu) ? aluSub : aluAdd;
                    ctrlD.regWrite = 1'b1;
                    ctrlD.dest     = instrD.r.rd;
                    ctrlD.tNew     = tNewAlu;
                    tUseRs         = tUseAlu;
                    tUseRt         = tUseAlu;
                end
            end
            opOri, opLui, opLw: begin
                ctrlD.aluOp    = (instrD.i.opcode == opOri) ? aluOr :
                                 (instrD.i.opcode == opLui) ? aluLui : aluAdd;
                ctrlD.immB     = 1'b1;
                ctrlD.zeroExt  = (instrD.i.opcode == opOri);
                ctrlD.memRead  = (instrD.i.opcode == opLw);
                ctrlD.regWrite = 1'b1;
                ctrlD.dest     = instrD.i.rt;
                ctrlD.tNew     = (instrD.i.opcode == opLw) ? tNewLoad : tNewAlu;
                tUseRs         = (instrD.i.opcode == opLui) ? tUseNone : tUseAlu;
            end
            opSw: begin
                ctrlD.immB     = 1'b1;
                ctrlD.memWrite = 1'b1;
                tUseRs         = tUseAlu;
                tUseRt         = tUseStore;
            end
            opBeq: begin
                isBeq  = 1'b1;
                tUseRs = tUseBranch;
                tUseRt = tUseBranch;
            end
            opJ: begin
                jump = 1'b1;
            end
            opJal: begin
                jump           = 1'b1;
                ctrlD.regWrite = 1'b1;
                ctrlD.dest     = linkReg;
                ctrlD.tNew     = tNewLink;
            end
            default: begin
            end
        endcase
    end

    assign rsHitEx  = hits(exStage.ctrl, instrD.r.rs);
    assign rsHitMem = hits(memStage.ctrl, instrD.r.rs);
    assign rtHitEx  = hits(exStage.ctrl, instrD.r.rt);
    assign rtHitMem = hits(memStage.ctrl, instrD.r.rt);

    // Hold decode while a needed value is still on its way
    assign stall = (rsHitEx && tUseRs < exStage.ctrl.tNew) ||
                   (rsHitMem && tUseRs < memStage.ctrl.tNew) ||
                   (rtHitEx && tUseRt < exStage.ctrl.tNew) ||
                   (rtHitMem && tUseRt < memStage.ctrl.tNew);
    assign flush = stall;

    // Youngest producer wins
    assign fwdRs = rsHitEx ? exStage.result : rsHitMem ? memResult : rsVal;
    assign fwdRt = rtHitEx ? exStage.result : rtHitMem ? memResult : rtVal;

    assign branchTaken = isBeq && (fwdRs == fwdRt);

    // Selects for the next cycle, when each producer has moved one stage on
    assign exFwdRs = rsHitEx ? fwdMem : rsHitMem ? fwdWb : fwdReg;
    assign exFwdRt = rtHitEx ? fwdMem : rtHitMem ? fwdWb : fwdReg;

endmodule

// File: logic/regFile.sv
module regFile
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  regIdxT      rsIdx,
    input  regIdxT      rtIdx,
    input  wbT          wb,
    input  logic        wbEn,
    output logic [31:0] rsVal,
    output logic [31:0] rtVal
);

    logic [31:0] regs [1:31];

    // Register 0 is hardwired, a same-cycle write is passed through
    function automatic logic [31:0] readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbEn && wb.dest == idx) begin
            return wb.value;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rsVal = readReg(rsIdx);
        rtVal = readReg(rtIdx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wb.dest] <= wb.value;
        end
    end

    noWriteToZero: assert property (@(posedge clk) disable iff (reset) wbEn |-> wb.dest != '0);

endmodule

// File: logic/fetchUnit.sv
module fetchUnit
    import isaPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic        jump,
    input  logic [31:0] fwdRs,
    output logic [31:0] pcD,
    output instrU       instrD,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] slotPc;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;

    // Targets are relative to the delay slot
    assign slotPc       = pcD + 32'd4;
    assign branchTarget = slotPc + {{14{instrD.i.imm[15]}}, instrD.i.imm, 2'b00};
    assign jumpTarget   = {slotPc[31:28], instrD.j.target, 2'b00};

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (jump) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    // PC and fetch/decode register freeze together on a stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
        if (reset) begin
            pc     <= resetPc;
            instrD <= '0;
        end else if (!stall) begin
            pc     <= pcNext;
            instrD <= instr;
        end
    end

    assign instrAddr = pc;

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

    // Forwarded rs operand of decode is resolved in every cycle
    rsOperandKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(fwdRs));

endmodule

// File: logic/pipePkg.sv
package pipePkg;
    import isaPkg::*;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpT;

    typedef logic [1:0] tickT;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelT;

    // Stage at which a source is needed, counted from decode
    localparam tickT tUseBranch = 2'd0;
    localparam tickT tUseAlu    = 2'd1;
    localparam tickT tUseStore  = 2'd2;
    // Never below any tNew, so an unused source cannot stall
    localparam tickT tUseNone   = 2'd3;

    // Cycles until the result exists, seen from execute
    localparam tickT tNewLoad = 2'd2;
    localparam tickT tNewAlu  = 2'd1;
    localparam tickT tNewLink = 2'd0;

    typedef struct packed {
        aluOpT  aluOp;
        logic   immB;
        logic   zeroExt;
        logic   memWrite;
        logic   memRead;
        logic   regWrite;
        regIdxT dest;
        tickT   tNew;
    } ctrlT;

    localparam ctrlT bubbleCtrl = '{
        aluOp: aluAdd, immB: 1'b0, zeroExt: 1'b0, memWrite: 1'b0,
        memRead: 1'b0, regWrite: 1'b0, dest: 5'd0, tNew: 2'd0
    };

    typedef struct packed {
        logic [31:0] pc;
        instrU       instr;
        ctrlT        ctrl;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] result;
    } stageT;

    typedef struct packed {
        logic [31:0] pc;
        regIdxT      dest;
        logic [31:0] value;
    } wbT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } memReqT;

endpackage

// File: logic/isaPkg.sv
package isaPkg;

    // First fetch address after reset
    localparam logic [31:0] resetPc = 32'h0000_3000;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;

    // Function codes under opSpecial
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;

    typedef logic [4:0] regIdxT;

    // Link register written by jal
    localparam regIdxT linkReg = 5'd31;

    typedef struct packed {
        logic [5:0] opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm;
    } iFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFieldsT;

    // Same word seen through the R, I and J formats
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        jFieldsT j;
    } instrU;

endpackage
